// ==== lsu_subsystem.f ====
+incdir+verilog
verilog/lsu_pkg.sv
verilog/load_store_unit.sv
verilog/lsu_regfile.sv
verilog/data_ram.sv
verilog/remote_bus_bridge.sv
verilog/lsu_subsystem.sv
dv/lsu_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the LSU subsystem testbench with Verilator.
# Run from the project root.

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal \
    --top-module lsu_subsystem_tb \
    -f lsu_subsystem.f \
    -o lsu_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/lsu_sim > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$SIM_LOG"
    echo "simulation exited with an error, see $SIM_LOG"
    exit 1
fi

cat "$SIM_LOG"
if grep -q "Result: PASSED" "$SIM_LOG"; then
    exit 0
fi
exit 1

// ==== dv/lsu_stim.txt ====
# hex fields: D reg val | P ptr val | O op | A store reg addr | L reg data
# B we adr sel dat | R reg val | W wait idle | T test number
D 1 a1b2c3d4
D 2 000000e5
D 3 00007788
P 1 00000100
P 2 00000200
P 3 80000040
O 5009
O 404a
O 484b
O 100c
L 4 7788e5d4
O 00cd
L 5 00000077
O 080e
L 6 0000e5d4
O 000f
L 7 000000d4
W
R 5 00000077
R 7 000000d4
T 1
O 7051
W
O 7793
W
O 1014
L 4 00007788
O 1055
L 5 a1b2c3d4
W
R 4 00007788
T 2
O 1809
L 9 7788e5d4
O 180a
L a 7788e5d4
W
R 9 7788e5d4
R a 7788e5d4
T 3
A 1 6 00000300
A 0 b 00000300
L b 0000e5d4
W
R b 0000e5d4
T 4
B 1 80000040 f a1b2c3d4
O 5019
W
B 1 80000040 4 e5e5e5e5
O 409a
W
B 0 80000040 c 00000000
O 0858
O 1808
L 8 7788e5d4
O 1809
L 9 7788e5d4
O 180a
L a 7788e5d4
O 180b
L b 7788e5d4
O 180c
L c 7788e5d4
O 180d
L d 7788e5d4
W
R 0 0000a1e5
R 8 7788e5d4
R d 7788e5d4
T 5

// ==== dv/lsu_subsystem_tb.sv ====
// testbench: clock, reset, stimulus file reader, Wishbone slave model, checker and report
`timescale 1ns/1ns
`default_nettype none

module lsu_subsystem_tb;
    import lsu_pkg::*;

    logic       clk = 1'b0;
    logic       rst;
    logic       op_vld;
    ls_op_t     op;
    logic       dir_vld;
    logic       dir_store;
    data_sel_t  dir_sel;
    data_word_t dir_addr;
    logic       ext_wr_en;
    data_sel_t  ext_wr_sel;
    data_word_t ext_wr_data;
    logic       ext_ptr_wr_en;
    ptr_sel_t   ext_ptr_wr_sel;
    data_word_t ext_ptr_wr_data;
    data_sel_t  dbg_sel;
    data_word_t dbg_data;
    logic       load_vld;
    data_sel_t  load_sel;
    data_word_t load_data;
    logic       remote_busy;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    data_word_t wb_adr;
    byte_mask_t wb_sel;
    data_word_t wb_dat_o;
    data_word_t wb_dat_i;
    logic       wb_ack;

    int         cyc_cnt = 0;
    int         cyc_limit = 0;
    int         errors = 0;
    int         checks = 0;
    int         tests = 0;
    int         issue_cyc = 0;
    int         exp_cyc_q [$];          // expected local writebacks.
    data_sel_t  exp_sel_q [$];
    data_word_t exp_data_q [$];
    logic       wb_we_q [$];            // expected Wishbone cycles.
    data_word_t wb_adr_q [$];
    byte_mask_t wb_sel_q [$];
    data_word_t wb_dat_q [$];
    data_word_t wb_mem [16];

    lsu_subsystem i_lsu_subsystem (.*);

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_limit > 0 && cyc_cnt >= cyc_limit)
        begin
            $display("timeout: run went past %0d cycles", cyc_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("[ERROR] %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // local writeback is sampled mid-cycle, away from the edges
    always @(negedge clk)
    begin
        if (!rst && load_vld)
        begin
            if (exp_cyc_q.size() == 0)
            begin
                $display("unexpected load writeback to register %0d at %0t", load_sel, $time);
                errors++;
            end
            else
            begin
                check("load_vld cycle", cyc_cnt, exp_cyc_q.pop_front());
                check("load_sel", load_sel, exp_sel_q.pop_front());
                check("load_data", load_data, exp_data_q.pop_front());
            end
        end
    end

    // Wishbone slave with a random ack delay of one to four cycles
    initial
    begin
        int delay;
        int idx;
        logic exp_known;
        logic exp_we;
        void'($urandom(78));
        wb_ack = 1'b0;
        wb_dat_i = '0;
        exp_we = 1'b0;
        for (idx = 0; idx < 16; idx++)
            wb_mem[idx] = 32'h5a000000 ^ (idx * 32'h01030507);
        forever
        begin
            step();
            if (wb_cyc)
            begin
                delay = $urandom % 4;   // extra wait cycles.
                repeat (delay)
                    step();
                idx = int'(wb_adr[5:2]);
                check("wb_stb", wb_stb, 1);
                exp_known = (wb_we_q.size() > 0);
                if (!exp_known)
                begin
                    $display("unexpected Wishbone cycle to %h at %0t", wb_adr, $time);
                    errors++;
                end
                else
                begin
                    exp_we = wb_we_q.pop_front();
                    check("wb_we", wb_we, exp_we);
                    check("wb_adr", wb_adr, wb_adr_q.pop_front());
                    check("wb_sel", wb_sel, wb_sel_q.pop_front());
                    if (wb_we)
                        check("wb_dat_o", wb_dat_o, wb_dat_q.pop_front());
                    else
                        void'(wb_dat_q.pop_front());
                end
                if (wb_we)
                begin
                    for (int i = 0; i < 4; i++)
                    begin
                        if (wb_sel[i])
                            wb_mem[idx][8*i +: 8] = wb_dat_o[8*i +: 8];
                    end
                end
                wb_dat_i = wb_mem[idx];
                wb_ack = 1'b1;
                step();
                wb_ack = 1'b0;
                check("wb_cyc", wb_cyc, 0);
                check("wb_stb", wb_stb, 0);
                if (exp_known)
                    check("remote_busy", remote_busy, !exp_we);   // a load still owes its write.
            end
        end
    end

    task automatic run_stimulus(input int fd);
        string line;
        byte cmd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        while ($fgets(line, fd) > 0)
        begin
            if (line.len() < 2 || line[0] == "#")
                continue;
            cmd = line[0];
            a = '0;
            b = '0;
            c = '0;
            d = '0;
            void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d));
            case (cmd)
                "D":
                begin
                    ext_wr_en = 1'b1;
                    ext_wr_sel = a[3:0];
                    ext_wr_data = b;
                    step();
                    ext_wr_en = 1'b0;
                end
                "P":
                begin
                    ext_ptr_wr_en = 1'b1;
                    ext_ptr_wr_sel = a[2:0];
                    ext_ptr_wr_data = b;
                    step();
                    ext_ptr_wr_en = 1'b0;
                end
                "O":
                begin
                    op_vld = 1'b1;
                    op = a[14:0];
                    issue_cyc = cyc_cnt;
                    step();
                    op_vld = 1'b0;
                end
                "A":
                begin
                    dir_vld = 1'b1;
                    dir_store = a[0];
                    dir_sel = b[3:0];
                    dir_addr = c;
                    issue_cyc = cyc_cnt;
                    step();
                    dir_vld = 1'b0;
                end
                "L":
                begin
                    exp_cyc_q.push_back(issue_cyc + 3);   // fixed local load latency.
                    exp_sel_q.push_back(a[3:0]);
                    exp_data_q.push_back(b);
                end
                "B":
                begin
                    wb_we_q.push_back(a[0]);
                    wb_adr_q.push_back(b);
                    wb_sel_q.push_back(c[3:0]);
                    wb_dat_q.push_back(d);
                end
                "W":
                begin
                    step();
                    step();             // pointer write lands one cycle later.
                    while (remote_busy || exp_cyc_q.size() > 0)
                        step();
                end
                "R":
                begin
                    dbg_sel = a[3:0];
                    #1;
                    check($sformatf("dbg_data[%0d]", a[3:0]), dbg_data, b);
                end
                "T":
                begin
                    tests++;
                    $display("test %0d done, %0d errors so far", a, errors);
                end
                default:
                begin
                    $display("unknown stimulus command: %s", line);
                    errors++;
                end
            endcase
        end
    endtask

    initial
    begin
        int fd;
        int n_lines;
        string line;
        rst = 1'b1;
        op_vld = 1'b0;
        op = '0;
        dir_vld = 1'b0;
        dir_store = 1'b0;
        dir_sel = '0;
        dir_addr = '0;
        ext_wr_en = 1'b0;
        ext_wr_sel = '0;
        ext_wr_data = '0;
        ext_ptr_wr_en = 1'b0;
        ext_ptr_wr_sel = '0;
        ext_ptr_wr_data = '0;
        dbg_sel = '0;
        n_lines = 0;
        fd = $fopen("dv/lsu_stim.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open stimulus file dv/lsu_stim.txt");
            $display("Result: FAILED");
            $finish;
        end
        else
        begin
            while ($fgets(line, fd) > 0)
                n_lines++;
            $fclose(fd);
            cyc_limit = 10 * n_lines;
            repeat (16)
                step();
            rst = 1'b0;
            check("wb_cyc", wb_cyc, 0);
            check("wb_stb", wb_stb, 0);
            check("remote_busy", remote_busy, 0);
            check("load_vld", load_vld, 0);
            fd = $fopen("dv/lsu_stim.txt", "r");
            run_stimulus(fd);
            $fclose(fd);
            if (exp_cyc_q.size() > 0 || wb_we_q.size() > 0)
            begin
                $display("expected writebacks or bus cycles never arrived");
                errors++;
            end
            $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
            if (errors == 0)
                $display("Result: PASSED");
            else
                $display("Result: FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lsu_subsystem.sv ====
// memory-access stage top: load/store unit, register file, local RAM and remote bridge
`timescale 1ns/1ns
`default_nettype none
`include "lsu_params.svh"

module lsu_subsystem
(
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                op_vld,
    input  wire lsu_pkg::ls_op_t     op,
    input  wire logic                dir_vld,
    input  wire logic                dir_store,
    input  wire lsu_pkg::data_sel_t  dir_sel,
    input  wire lsu_pkg::data_word_t dir_addr,
    input  wire logic                ext_wr_en,
    input  wire lsu_pkg::data_sel_t  ext_wr_sel,
    input  wire lsu_pkg::data_word_t ext_wr_data,
    input  wire logic                ext_ptr_wr_en,
    input  wire lsu_pkg::ptr_sel_t   ext_ptr_wr_sel,
    input  wire lsu_pkg::data_word_t ext_ptr_wr_data,
    input  wire lsu_pkg::data_sel_t  dbg_sel,
    output lsu_pkg::data_word_t      dbg_data,
    output logic                     load_vld,
    output lsu_pkg::data_sel_t       load_sel,
    output lsu_pkg::data_word_t      load_data,
    output logic                     remote_busy,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output lsu_pkg::data_word_t      wb_adr,
    output lsu_pkg::byte_mask_t      wb_sel,
    output lsu_pkg::data_word_t      wb_dat_o,
    input  wire lsu_pkg::data_word_t wb_dat_i,
    input  wire logic                wb_ack
);
    import lsu_pkg::*;

    localparam int ram_aw = $clog2(`LSU_RAM_WORDS);

    ptr_sel_t   ptr_sel;
    data_word_t ptr_data;
    data_sel_t  store_sel;
    data_word_t store_data;
    logic       ptr_upd_vld;
    ptr_sel_t   ptr_upd_sel;
    data_word_t ptr_upd;
    data_word_t daddr;
    logic       dcs;
    logic       rcn_cs;
    logic       dwr;
    byte_mask_t dmask;
    data_word_t dout;
    data_sel_t  writeback_reg;
    data_word_t din;
    logic       rmt_wr_en;
    data_sel_t  rmt_wr_sel;
    data_word_t rmt_wr_data;

    load_store_unit i_load_store_unit
    (
        .clk(clk), .rst(rst),
        .op_vld(op_vld), .op(op),
        .dir_vld(dir_vld), .dir_store(dir_store), .dir_sel(dir_sel), .dir_addr(dir_addr),
        .ptr_sel(ptr_sel), .ptr_data(ptr_data),
        .store_sel(store_sel), .store_data(store_data),
        .ptr_upd_vld(ptr_upd_vld), .ptr_upd_sel(ptr_upd_sel), .ptr_upd(ptr_upd),
        .daddr(daddr), .dcs(dcs), .rcn_cs(rcn_cs), .dwr(dwr), .dmask(dmask),
        .dout(dout), .writeback_reg(writeback_reg), .din(din),
        .load_vld(load_vld), .load_sel(load_sel), .load_data(load_data)
    );

    lsu_regfile i_lsu_regfile
    (
        .clk(clk), .rst(rst),
        .ptr_sel(ptr_sel), .ptr_data(ptr_data),
        .store_sel(store_sel), .store_data(store_data),
        .ptr_upd_vld(ptr_upd_vld), .ptr_upd_sel(ptr_upd_sel), .ptr_upd(ptr_upd),
        .load_vld(load_vld), .load_sel(load_sel), .load_data(load_data),
        .rmt_wr_en(rmt_wr_en), .rmt_wr_sel(rmt_wr_sel), .rmt_wr_data(rmt_wr_data),
        .ext_wr_en(ext_wr_en), .ext_wr_sel(ext_wr_sel), .ext_wr_data(ext_wr_data),
        .ext_ptr_wr_en(ext_ptr_wr_en), .ext_ptr_wr_sel(ext_ptr_wr_sel),
        .ext_ptr_wr_data(ext_ptr_wr_data),
        .dbg_sel(dbg_sel), .dbg_data(dbg_data)
    );

    // word index from the byte address
    data_ram #(.depth_words(`LSU_RAM_WORDS)) i_data_ram
    (
        .clk(clk), .cs(dcs), .wr(dwr),
        .addr(daddr[ram_aw+1:2]), .mask(dmask),
        .wdata(dout), .rdata(din)
    );

    remote_bus_bridge i_remote_bus_bridge
    (
        .clk(clk), .rst(rst),
        .rcn_cs(rcn_cs), .dwr(dwr), .daddr(daddr), .dmask(dmask), .dout(dout),
        .writeback_reg(writeback_reg), .load_vld(load_vld),
        .remote_busy(remote_busy),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_sel(wb_sel), .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .rmt_wr_en(rmt_wr_en), .rmt_wr_sel(rmt_wr_sel), .rmt_wr_data(rmt_wr_data)
    );

endmodule

`default_nettype wire

// ==== verilog/remote_bus_bridge.sv ====
// remote bridge: request latch, Wishbone classic master cycle, load return to register file
`timescale 1ns/1ns
`default_nettype none

module remote_bus_bridge
(
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                rcn_cs,
    input  wire logic                dwr,
    input  wire lsu_pkg::data_word_t daddr,
    input  wire lsu_pkg::byte_mask_t dmask,
    input  wire lsu_pkg::data_word_t dout,
    input  wire lsu_pkg::data_sel_t  writeback_reg,
    input  wire logic                load_vld,
    output logic                     remote_busy,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output lsu_pkg::data_word_t      wb_adr,
    output lsu_pkg::byte_mask_t      wb_sel,
    output lsu_pkg::data_word_t      wb_dat_o,
    input  wire lsu_pkg::data_word_t wb_dat_i,
    input  wire logic                wb_ack,
    output logic                     rmt_wr_en,
    output lsu_pkg::data_sel_t       rmt_wr_sel,
    output lsu_pkg::data_word_t      rmt_wr_data
);
    import lsu_pkg::*;

    bridge_state_t state;
    data_word_t    lane_data;

    // lane taken from the latched byte mask
    always_comb
    begin
        case (wb_sel)
            4'b1100: lane_data = {16'd0, wb_dat_i[31:16]};
            4'b0011: lane_data = {16'd0, wb_dat_i[15:0]};
            4'b1000: lane_data = {24'd0, wb_dat_i[31:24]};
            4'b0100: lane_data = {24'd0, wb_dat_i[23:16]};
            4'b0010: lane_data = {24'd0, wb_dat_i[15:8]};
            4'b0001: lane_data = {24'd0, wb_dat_i[7:0]};
            default: lane_data = wb_dat_i;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state  <= bridge_idle;
            wb_cyc <= 1'b0;
        end
        else
        begin
            case (state)
                bridge_idle:
                begin
                    if (rcn_cs)
                    begin
                        state  <= bridge_bus;
                        wb_cyc <= 1'b1;
                    end
                end
                bridge_bus:
                begin
                    if (wb_ack)
                    begin
                        wb_cyc <= 1'b0;
                        state  <= wb_we ? bridge_idle : bridge_return;
                    end
                end
                bridge_return:
                begin
                    if (!load_vld)      // local load owns the write port.
                        state <= bridge_idle;
                end
                default:
                    state <= bridge_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == bridge_idle && rcn_cs)
        begin
            wb_we      <= dwr;
            wb_adr     <= daddr;
            wb_sel     <= dmask;
            wb_dat_o   <= dout;
            rmt_wr_sel <= writeback_reg;
        end
        if (state == bridge_bus && wb_ack)
            rmt_wr_data <= lane_data;
    end

    assign wb_stb      = wb_cyc;
    assign remote_busy = rcn_cs || (state != bridge_idle);
    assign rmt_wr_en   = (state == bridge_return);

endmodule

`default_nettype wire

// ==== verilog/data_ram.sv ====
// local data RAM with byte-lane writes and registered read data
`timescale 1ns/1ns
`default_nettype none
`include "lsu_params.svh"

module data_ram
#(
    parameter int depth_words = `LSU_RAM_WORDS
)
(
    input  wire logic                           clk,
    input  wire logic                           cs,
    input  wire logic                           wr,
    input  wire logic [$clog2(depth_words)-1:0] addr,
    input  wire lsu_pkg::byte_mask_t            mask,
    input  wire lsu_pkg::data_word_t            wdata,
    output lsu_pkg::data_word_t                 rdata
);
    import lsu_pkg::*;

    data_word_t mem [depth_words];

    always_ff @(posedge clk)
    begin
        if (cs)
        begin
            if (wr)
            begin
                for (int i = 0; i < 4; i++)
                begin
                    if (mask[i])
                        mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            else
            begin
                rdata <= mem[addr];     // held until the next read.
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lsu_regfile.sv ====
// data and pointer register file with operand, debug and prioritized write ports
`timescale 1ns/1ns
`default_nettype none
`include "lsu_params.svh"

module lsu_regfile
(
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire lsu_pkg::ptr_sel_t   ptr_sel,
    output lsu_pkg::data_word_t      ptr_data,
    input  wire lsu_pkg::data_sel_t  store_sel,
    output lsu_pkg::data_word_t      store_data,
    input  wire logic                ptr_upd_vld,
    input  wire lsu_pkg::ptr_sel_t   ptr_upd_sel,
    input  wire lsu_pkg::data_word_t ptr_upd,
    input  wire logic                load_vld,
    input  wire lsu_pkg::data_sel_t  load_sel,
    input  wire lsu_pkg::data_word_t load_data,
    input  wire logic                rmt_wr_en,
    input  wire lsu_pkg::data_sel_t  rmt_wr_sel,
    input  wire lsu_pkg::data_word_t rmt_wr_data,
    input  wire logic                ext_wr_en,
    input  wire lsu_pkg::data_sel_t  ext_wr_sel,
    input  wire lsu_pkg::data_word_t ext_wr_data,
    input  wire logic                ext_ptr_wr_en,
    input  wire lsu_pkg::ptr_sel_t   ext_ptr_wr_sel,
    input  wire lsu_pkg::data_word_t ext_ptr_wr_data,
    input  wire lsu_pkg::data_sel_t  dbg_sel,
    output lsu_pkg::data_word_t      dbg_data
);
    import lsu_pkg::*;

    data_word_t data_regs [`LSU_NUM_DATA_REGS];
    data_word_t ptr_regs [`LSU_NUM_PTR_REGS];
    logic       data_we;
    data_sel_t  data_wsel;
    data_word_t data_wval;
    logic       ptr_we;
    ptr_sel_t   ptr_wsel;
    data_word_t ptr_wval;

    assign ptr_data   = ptr_regs[ptr_sel];
    assign store_data = data_regs[store_sel];
    assign dbg_data   = data_regs[dbg_sel];

    // local load, then remote return, then external port
    always_comb
    begin
        data_we   = load_vld || rmt_wr_en || ext_wr_en;
        data_wsel = load_vld ? load_sel : rmt_wr_en ? rmt_wr_sel : ext_wr_sel;
        data_wval = load_vld ? load_data : rmt_wr_en ? rmt_wr_data : ext_wr_data;
        ptr_we    = ptr_upd_vld || ext_ptr_wr_en;
        ptr_wsel  = ptr_upd_vld ? ptr_upd_sel : ext_ptr_wr_sel;
        ptr_wval  = ptr_upd_vld ? ptr_upd : ext_ptr_wr_data;
    end

    always_ff @(posedge clk)
    begin
        if (!rst && data_we)            // no writes while held in reset.
            data_regs[data_wsel] <= data_wval;
        if (!rst && ptr_we)
            ptr_regs[ptr_wsel] <= ptr_wval;
    end

endmodule

`default_nettype wire

// ==== verilog/load_store_unit.sv ====
// load/store unit: operation decode, address and pointer update, bus drive, load alignment
`timescale 1ns/1ns
`default_nettype none
`include "lsu_params.svh"

module load_store_unit
(
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                op_vld,
    input  wire lsu_pkg::ls_op_t     op,
    input  wire logic                dir_vld,
    input  wire logic                dir_store,
    input  wire lsu_pkg::data_sel_t  dir_sel,
    input  wire lsu_pkg::data_word_t dir_addr,
    output lsu_pkg::ptr_sel_t        ptr_sel,
    input  wire lsu_pkg::data_word_t ptr_data,
    output lsu_pkg::data_sel_t       store_sel,
    input  wire lsu_pkg::data_word_t store_data,
    output logic                     ptr_upd_vld,
    output lsu_pkg::ptr_sel_t        ptr_upd_sel,
    output lsu_pkg::data_word_t      ptr_upd,
    output lsu_pkg::data_word_t      daddr,
    output logic                     dcs,
    output logic                     rcn_cs,
    output logic                     dwr,
    output lsu_pkg::byte_mask_t      dmask,
    output lsu_pkg::data_word_t      dout,
    output lsu_pkg::data_sel_t       writeback_reg,
    input  wire lsu_pkg::data_word_t din,
    output logic                     load_vld,
    output lsu_pkg::data_sel_t       load_sel,
    output lsu_pkg::data_word_t      load_data
);
    import lsu_pkg::*;

    logic       op_go;
    logic       acc_go;
    logic       is_word;
    logic       is_half;
    logic       wr_en;
    logic       remote;
    data_sel_t  data_reg;
    data_word_t offset;
    data_word_t adjust;
    data_word_t addr_next;
    data_word_t addr_out;
    data_word_t wr_data;
    byte_mask_t lane_mask;
    logic [2:0] ld_vld;                 // local load in flight, one bit per stage.
    logic [7:0] ld_tag [3];             // {size, lane, destination}.
    data_word_t rd_data;
    logic [1:0] tag_size;
    logic [1:0] tag_lane;

    assign op_go    = op_vld && !dir_vld;   // direct access wins.
    assign acc_go   = op_vld || dir_vld;
    assign is_word  = dir_vld || op[12];
    assign is_half  = !is_word && op[11];
    assign data_reg = dir_vld ? dir_sel : {op[12] & op[11], op[2:0]};

    assign ptr_sel   = op[5:3];
    assign store_sel = data_reg;

    // offset scaled by access size
    always_comb
    begin
        if (op[12])
        begin
            offset = {25'd0, op[10:6], 2'b00};
            adjust = {{25{op[10]}}, op[10:6], 2'b00};
        end
        else if (op[11])
        begin
            offset = {26'd0, op[10:6], 1'b0};
            adjust = {{26{op[10]}}, op[10:6], 1'b0};
        end
        else
        begin
            offset = {27'd0, op[10:6]};
            adjust = {{27{op[10]}}, op[10:6]};
        end
    end

    assign addr_next = ptr_data + (op[13] ? adjust : offset);
    // post-increment uses the old pointer, pre-decrement the new one
    assign addr_out  = dir_vld ? dir_addr :
                       (op[13] && !adjust[31]) ? ptr_data : addr_next;
    assign remote    = addr_out[`LSU_REMOTE_BIT];
    assign wr_en     = dir_vld ? dir_store : op[14];

    always_comb
    begin
        if (is_word)
        begin
            wr_data   = store_data;
            lane_mask = 4'b1111;
        end
        else if (is_half)
        begin
            wr_data   = {2{store_data[15:0]}};
            lane_mask = addr_out[1] ? 4'b1100 : 4'b0011;
        end
        else
        begin
            wr_data   = {4{store_data[7:0]}};
            lane_mask = 4'b0001 << addr_out[1:0];
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ptr_upd_vld <= 1'b0;
            dcs         <= 1'b0;
            rcn_cs      <= 1'b0;
            ld_vld      <= 3'b000;
        end
        else
        begin
            ptr_upd_vld <= op_go && op[13];
            dcs         <= acc_go && !remote;
            rcn_cs      <= acc_go && remote;
            ld_vld      <= {ld_vld[1:0], acc_go && !wr_en && !remote};
        end
    end

    always_ff @(posedge clk)
    begin
        if (op_go)
        begin
            ptr_upd_sel <= op[5:3];
            ptr_upd     <= addr_next;
        end
        if (acc_go)
        begin
            daddr         <= {addr_out[31:2], 2'b00};
            dwr           <= wr_en;
            dmask         <= lane_mask;
            dout          <= wr_data;
            writeback_reg <= data_reg;
        end
        ld_tag[0] <= {is_word, is_half, addr_out[1:0], data_reg};
        ld_tag[1] <= ld_tag[0];
        ld_tag[2] <= ld_tag[1];
        if (ld_vld[1])
            rd_data <= din;             // RAM data valid one cycle after select.
    end

    assign tag_size = ld_tag[2][7:6];
    assign tag_lane = ld_tag[2][5:4];

    always_comb
    begin
        if (tag_size[1])
            load_data = rd_data;
        else if (tag_size[0])
            load_data = tag_lane[1] ? {16'd0, rd_data[31:16]} : {16'd0, rd_data[15:0]};
        else
            load_data = {24'd0, rd_data[8*tag_lane +: 8]};
    end

    assign load_vld = ld_vld[2];
    assign load_sel = ld_tag[2][3:0];

endmodule

`default_nettype wire

// ==== verilog/lsu_pkg.sv ====
// word, mask, register select, operation and bridge state types
`default_nettype none

package lsu_pkg;

    typedef logic [31:0] data_word_t;   // data and address word.
    typedef logic [3:0]  byte_mask_t;   // one enable per byte lane.
    typedef logic [3:0]  data_sel_t;    // data register index.
    typedef logic [2:0]  ptr_sel_t;     // pointer register index.

    // 14 store, 13 ptr update, 12 word, 11 half or upper bank,
    // 10:6 offset, 5:3 pointer, 2:0 data register
    typedef logic [14:0] ls_op_t;

    typedef enum logic [1:0]
    {
        bridge_idle,
        bridge_bus,
        bridge_return
    } bridge_state_t;

endpackage

`default_nettype wire

// ==== verilog/lsu_params.svh ====
// register counts, local RAM depth and remote-space address bit
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// register file size
`define LSU_NUM_DATA_REGS 16
`define LSU_NUM_PTR_REGS 8

// local RAM depth in 32-bit words, power of two
`define LSU_RAM_WORDS 256

// set in an address for the remote space
`define LSU_REMOTE_BIT 31

`endif
